// ==== hw/cache_bank.sv ====
/*
 * Cache bank
 * Direct-mapped, write-through, no allocation on a write miss.
 * Fixed priority selection of init, replay, fill and core request,
 * a two-stage lookup pipeline, one pending read miss, and queued
 * core responses and memory requests. A full queue stalls the pipe.
 */
`timescale 1ns/10ps

module cache_bank
    import cache_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,

    input  logic                      core_req_valid,
    input  logic [LINE_ADDR_BITS-1:0] core_req_addr,
    input  logic                      core_req_rw,
    input  logic [WSEL_BITS-1:0]      core_req_wsel,
    input  logic [BYTEEN_BITS-1:0]    core_req_byteen,
    input  logic [WORD_BITS-1:0]      core_req_data,
    input  logic [REQ_TAG_BITS-1:0]   core_req_tag,
    output logic                      core_req_ready,

    output logic                      core_rsp_valid,
    output logic [WORD_BITS-1:0]      core_rsp_data,
    output logic [REQ_TAG_BITS-1:0]   core_rsp_tag,
    input  logic                      core_rsp_ready,

    output logic                      mem_req_valid,
    output logic [LINE_ADDR_BITS-1:0] mem_req_addr,
    output logic                      mem_req_rw,
    output logic [WSEL_BITS-1:0]      mem_req_wsel,
    output logic [BYTEEN_BITS-1:0]    mem_req_byteen,
    output logic [WORD_BITS-1:0]      mem_req_data,
    input  logic                      mem_req_ready,

    input  logic                      mem_rsp_valid,
    input  logic [LINE_BITS-1:0]      mem_rsp_data,
    output logic                      mem_rsp_ready,

    input  logic                      init_enable,
    input  logic [SET_BITS-1:0]       init_line_sel
);

    logic                    stall;
    logic                    miss_busy;
    logic                    replay_valid;
    line_addr_t              replay_addr;
    logic [WSEL_BITS-1:0]    replay_wsel;
    logic [REQ_TAG_BITS-1:0] replay_tag;
    logic                    rsp_full, rsp_empty;
    logic                    mreq_full, mreq_empty;
    logic                    hit_st0;
    logic [WORD_BITS-1:0]    read_data_st1;
    line_addr_t              addr_sel;

    // stage registers
    logic                    valid_st0, valid_st1;
    logic                    is_init_st0, is_init_st1;
    logic                    is_fill_st0, is_fill_st1;
    logic                    is_replay_st0, is_replay_st1;
    logic                    rw_st0, rw_st1;
    logic                    hit_st1;
    line_addr_t              addr_st0, addr_st1;
    logic [WSEL_BITS-1:0]    wsel_st0, wsel_st1;
    logic [BYTEEN_BITS-1:0]  byteen_st0, byteen_st1;
    logic [REQ_TAG_BITS-1:0] tag_st0, tag_st1;
    logic [LINE_BITS-1:0]    data_st0, data_st1;

    // a read in stage 0 that will miss, seen before it allocates
    wire read_miss_st0 = valid_st0 && !is_init_st0 && !is_fill_st0 && !rw_st0 && !hit_st0;

    wire read_st1       = valid_st1 && !is_init_st1 && !is_fill_st1 && !rw_st1;
    wire read_hit_st1   = read_st1 && hit_st1;
    wire read_miss_st1  = read_st1 && !hit_st1;
    wire write_st1      = valid_st1 && rw_st1;
    wire write_hit_st1  = write_st1 && hit_st1;
    wire fill_st1       = valid_st1 && is_fill_st1;

    // arbitration: init, replay, fill, core request
    wire creq_grant = !init_enable && !replay_valid && !mem_rsp_valid;

    assign core_req_ready = creq_grant && !miss_busy && !read_miss_st0
                         && !read_miss_st1 && !stall;
    assign mem_rsp_ready  = !init_enable && !replay_valid && !stall;

    wire replay_taken  = !init_enable && replay_valid && !stall;
    wire fill_fire     = mem_rsp_valid && mem_rsp_ready;
    wire core_req_fire = core_req_valid && core_req_ready;

    always_comb begin
        addr_sel.raw = core_req_addr;
        if (init_enable) begin
            addr_sel.split.tag = '0;
            addr_sel.split.set = init_line_sel;
        end else if (replay_valid || mem_rsp_valid) begin
            // fill address comes from the pending miss
            addr_sel = replay_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_st0 <= 1'b0;
            valid_st1 <= 1'b0;
        end else if (!stall) begin
            valid_st0 <= init_enable || replay_taken || fill_fire || core_req_fire;
            valid_st1 <= valid_st0;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            is_init_st0   <= init_enable;
            is_replay_st0 <= !init_enable && replay_valid;
            is_fill_st0   <= !init_enable && !replay_valid && mem_rsp_valid;
            rw_st0        <= creq_grant && core_req_rw;
            addr_st0      <= addr_sel;
            wsel_st0      <= replay_valid ? replay_wsel : core_req_wsel;
            byteen_st0    <= core_req_byteen;
            tag_st0       <= replay_valid ? replay_tag : core_req_tag;
            data_st0      <= mem_rsp_valid ? mem_rsp_data : LINE_BITS'(core_req_data);

            is_init_st1   <= is_init_st0;
            is_replay_st1 <= is_replay_st0;
            is_fill_st1   <= is_fill_st0;
            rw_st1        <= rw_st0;
            hit_st1       <= hit_st0;
            addr_st1      <= addr_st0;
            wsel_st1      <= wsel_st0;
            byteen_st1    <= byteen_st0;
            tag_st1       <= tag_st0;
            data_st1      <= data_st0;
        end
    end

    // stage 1 push needs and back-pressure
    wire rsp_need  = read_hit_st1;
    wire mreq_need = write_st1 || read_miss_st1;

    assign stall = (rsp_need && rsp_full) || (mreq_need && mreq_full);

    tag_store tag_store_inst (
        .clk         (clk),
        .reset       (reset),
        .lookup_addr (addr_st0),
        .fill        (valid_st0 && is_fill_st0 && !stall),
        .init        (valid_st0 && is_init_st0 && !stall),
        .init_set    (addr_st0.split.set),
        .hit         (hit_st0)
    );

    data_store data_store_inst (
        .clk        (clk),
        .addr       (addr_st1),
        .write      (write_hit_st1 && !stall),
        .fill       (fill_st1 && !stall),
        .wsel       (wsel_st1),
        .byteen     (byteen_st1),
        .write_data (data_st1[WORD_BITS-1:0]),
        .fill_data  (data_st1),
        .read_data  (read_data_st1)
    );

    miss_slot miss_slot_inst (
        .clk          (clk),
        .reset        (reset),
        .allocate     (read_miss_st1 && !stall),
        .alloc_addr   (addr_st1),
        .alloc_wsel   (wsel_st1),
        .alloc_tag    (tag_st1),
        .fill_taken   (fill_fire),
        .replay_valid (replay_valid),
        .replay_addr  (replay_addr),
        .replay_wsel  (replay_wsel),
        .replay_tag   (replay_tag),
        .replay_taken (replay_taken),
        .busy         (miss_busy)
    );

    sync_fifo #(
        .WIDTH (REQ_TAG_BITS + WORD_BITS),
        .DEPTH (RSP_DEPTH)
    ) rsp_queue (
        .clk      (clk),
        .reset    (reset),
        .push     (rsp_need && !stall),
        .pop      (core_rsp_valid && core_rsp_ready),
        .data_in  ({tag_st1, read_data_st1}),
        .data_out ({core_rsp_tag, core_rsp_data}),
        .empty    (rsp_empty),
        .full     (rsp_full)
    );

    assign core_rsp_valid = !rsp_empty;

    // write-through for every write, line read for a read miss
    sync_fifo #(
        .WIDTH (1 + LINE_ADDR_BITS + WSEL_BITS + BYTEEN_BITS + WORD_BITS),
        .DEPTH (MREQ_DEPTH)
    ) mreq_queue (
        .clk      (clk),
        .reset    (reset),
        .push     (mreq_need && !stall),
        .pop      (mem_req_valid && mem_req_ready),
        .data_in  ({rw_st1, addr_st1.raw, wsel_st1, byteen_st1, data_st1[WORD_BITS-1:0]}),
        .data_out ({mem_req_rw, mem_req_addr, mem_req_wsel, mem_req_byteen, mem_req_data}),
        .empty    (mreq_empty),
        .full     (mreq_full)
    );

    assign mem_req_valid = !mreq_empty;

    // the fill has written the tag one cycle before the replay looks up
    replay_hits: assert property (@(posedge clk) disable iff (reset)
        (valid_st1 && is_replay_st1) |-> hit_st1)
        else $error("cache_bank: replay missed in stage 1");

    init_when_idle: assert property (@(posedge clk) disable iff (reset)
        init_enable |-> (!miss_busy && rsp_empty && mreq_empty
                         && !(valid_st0 && !is_init_st0)
                         && !(valid_st1 && !is_init_st1)))
        else $error("cache_bank: init while the bank is active");

endmodule

// ==== hw/cache_pkg.sv ====
/*
 * Cache bank package
 * Geometry of one direct-mapped bank and the line address type.
 * A line address is read either as a flat value or as tag over set.
 */
package cache_pkg;

    // line addressing
    localparam int LINE_ADDR_BITS = 12;
    localparam int SET_BITS       = 6;
    localparam int TAG_BITS       = LINE_ADDR_BITS - SET_BITS;
    localparam int NUM_SETS       = 64;

    // word and line geometry
    localparam int WORD_BITS      = 32;
    localparam int WORDS_PER_LINE = 4;
    localparam int LINE_BITS      = WORD_BITS * WORDS_PER_LINE;
    localparam int WSEL_BITS      = 2;
    localparam int BYTEEN_BITS    = WORD_BITS / 8;

    // core request tag carried back with the response
    localparam int REQ_TAG_BITS   = 4;

    // output queue depths
    localparam int RSP_DEPTH      = 2;
    localparam int MREQ_DEPTH     = 4;

    // tag in the upper bits, set index below it
    typedef struct packed {
        logic [TAG_BITS-1:0] tag;
        logic [SET_BITS-1:0] set;
    } line_split_t;

    typedef union packed {
        logic [LINE_ADDR_BITS-1:0] raw;
        line_split_t               split;
    } line_addr_t;

endpackage

// ==== hw/data_store.sv ====
/*
 * Data store
 * Line array of the bank. Merges a word under byte enables on a
 * write hit, replaces a whole line on a fill, and returns the
 * selected word combinationally.
 */
`timescale 1ns/10ps

module data_store
    import cache_pkg::*;
(
    input  logic                   clk,
    input  line_addr_t             addr,
    input  logic                   write,
    input  logic                   fill,
    input  logic [WSEL_BITS-1:0]   wsel,
    input  logic [BYTEEN_BITS-1:0] byteen,
    input  logic [WORD_BITS-1:0]   write_data,
    input  logic [LINE_BITS-1:0]   fill_data,
    output logic [WORD_BITS-1:0]   read_data
);

    logic [LINE_BITS-1:0] lines [NUM_SETS];
    logic [LINE_BITS-1:0] cur_line;
    logic [LINE_BITS-1:0] merged_line;

    assign cur_line = lines[addr.split.set];

    // byte merge of the write word into the current line
    always_comb begin
        merged_line = cur_line;
        for (int b = 0; b < BYTEEN_BITS; b++) begin
            if (byteen[b]) begin
                merged_line[wsel * WORD_BITS + b * 8 +: 8] = write_data[b * 8 +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            lines[addr.split.set] <= fill_data;
        end else if (write) begin
            lines[addr.split.set] <= merged_line;
        end
    end

    assign read_data = cur_line[wsel * WORD_BITS +: WORD_BITS];

    // a fill and a write hit come from different stage 1 items
    write_fill_excl: assert property (@(posedge clk) !(write && fill))
        else $error("data_store: write and fill in the same cycle");

endmodule

// ==== hw/miss_slot.sv ====
/*
 * Miss slot
 * Holds the single outstanding read miss of the bank. Supplies the
 * line address for the memory fill, then offers the stored read
 * for replay once the fill has been taken.
 */
`timescale 1ns/10ps

module miss_slot
    import cache_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    allocate,
    input  line_addr_t              alloc_addr,
    input  logic [WSEL_BITS-1:0]    alloc_wsel,
    input  logic [REQ_TAG_BITS-1:0] alloc_tag,
    input  logic                    fill_taken,
    output logic                    replay_valid,
    output line_addr_t              replay_addr,
    output logic [WSEL_BITS-1:0]    replay_wsel,
    output logic [REQ_TAG_BITS-1:0] replay_tag,
    input  logic                    replay_taken,
    output logic                    busy
);

    logic busy_q;
    logic filled_q;

    logic [TAG_BITS-1:0]     entry_tag;
    logic [SET_BITS-1:0]     entry_set;
    logic [WSEL_BITS-1:0]    entry_wsel;
    logic [REQ_TAG_BITS-1:0] entry_req_tag;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy_q   <= 1'b0;
            filled_q <= 1'b0;
        end else if (allocate) begin
            busy_q   <= 1'b1;
            filled_q <= 1'b0;
        end else if (replay_taken) begin
            busy_q   <= 1'b0;
            filled_q <= 1'b0;
        end else if (fill_taken) begin
            filled_q <= 1'b1;
        end
    end

    // stored read request
    always_ff @(posedge clk) begin
        if (allocate) begin
            entry_tag     <= alloc_addr.split.tag;
            entry_set     <= alloc_addr.split.set;
            entry_wsel    <= alloc_wsel;
            entry_req_tag <= alloc_tag;
        end
    end

    assign replay_addr.split.tag = entry_tag;
    assign replay_addr.split.set = entry_set;
    assign replay_wsel           = entry_wsel;
    assign replay_tag            = entry_req_tag;
    assign replay_valid          = busy_q && filled_q;
    assign busy                  = busy_q;

    // the bank blocks new core requests while a miss is pending
    single_miss: assert property (@(posedge clk) disable iff (reset) allocate |-> !busy_q)
        else $error("miss_slot: allocation while a miss is pending");

endmodule

// ==== hw/sync_fifo.sv ====
/*
 * Synchronous FIFO
 * Circular buffer with read and write pointers and an entry count.
 * A pushed item is visible at the output after the pushing edge.
 */
`timescale 1ns/10ps

module sync_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 2
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             push,
    input  logic             pop,
    input  logic [WIDTH-1:0] data_in,
    output logic [WIDTH-1:0] data_out,
    output logic             empty,
    output logic             full
);

    typedef logic [$clog2(DEPTH)-1:0]   ptr_t;
    typedef logic [$clog2(DEPTH+1)-1:0] cnt_t;

    logic [WIDTH-1:0] mem [DEPTH];
    ptr_t             rd_ptr;
    ptr_t             wr_ptr;
    cnt_t             count;

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == ptr_t'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_t'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // count only moves when exactly one side is active
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= data_in;
        end
    end

    assign data_out = mem[rd_ptr];
    assign empty    = (count == '0);
    assign full     = (count == cnt_t'(DEPTH));

    no_overflow: assert property (@(posedge clk) disable iff (reset) push |-> !full)
        else $error("sync_fifo: push while full");
    no_underflow: assert property (@(posedge clk) disable iff (reset) pop |-> !empty)
        else $error("sync_fifo: pop while empty");

endmodule

// ==== hw/tag_store.sv ====
/*
 * Tag store
 * One valid bit and one tag per set of the direct-mapped bank.
 * Lookup is combinational; fill and init write at the clock edge.
 */
`timescale 1ns/10ps

module tag_store
    import cache_pkg::*;
(
    input  logic                clk,
    input  logic                reset,
    input  line_addr_t          lookup_addr,
    input  logic                fill,
    input  logic                init,
    input  logic [SET_BITS-1:0] init_set,
    output logic                hit
);

    logic [NUM_SETS-1:0] valid_q;
    logic [TAG_BITS-1:0] tags [NUM_SETS];

    // valid bits, cleared on reset
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
        end else begin
            if (fill) begin
                valid_q[lookup_addr.split.set] <= 1'b1;
            end
            // init and fill never share a cycle
            if (init) begin
                valid_q[init_set] <= 1'b0;
            end
        end
    end

    // tag array, written by a fill only
    always_ff @(posedge clk) begin
        if (fill) begin
            tags[lookup_addr.split.set] <= lookup_addr.split.tag;
        end
    end

    assign hit = valid_q[lookup_addr.split.set]
              && (tags[lookup_addr.split.set] == lookup_addr.split.tag);

endmodule

// ==== run.sh ====
#!/bin/sh
# build the cache bank testbench with Verilator, run it, and scan the log

verilator --binary --timing --assert -Wno-fatal -f verilog.f \
    --top-module cache_bank_tb -o cache_bank_sim > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }

./obj_dir/cache_bank_sim > sim.log 2>&1

grep -q "Checks failed" sim.log && { echo "simulation FAILED, see sim.log"; exit 1; }
grep -q "All checks passed" sim.log || { echo "simulation did not finish, see sim.log"; exit 1; }
echo "simulation passed"

// ==== tests/cache_model.svh ====
/*
 * Cache bank reference model
 * Backing memory as seen by the memory port, core view of memory in
 * request order, and the valid bits and tags of a direct-mapped bank.
 */
`ifndef CACHE_MODEL_SVH
`define CACHE_MODEL_SVH

logic [WORD_BITS-1:0] backing_mem [int];
logic [WORD_BITS-1:0] shadow_mem [int];
logic                 model_valid [NUM_SETS];
logic [TAG_BITS-1:0]  model_tag [NUM_SETS];

function automatic int word_key(input logic [LINE_ADDR_BITS-1:0] line,
                                input logic [WSEL_BITS-1:0] wsel);
    return int'(line) * WORDS_PER_LINE + int'(wsel);
endfunction

// odd multiplier, so every word address gets its own value
function automatic logic [WORD_BITS-1:0] fill_pattern(input int key);
    return (WORD_BITS'(key) * 32'h9e37_79b1) ^ 32'h5a3c_0000;
endfunction

function automatic logic [WORD_BITS-1:0] merge_word(input logic [WORD_BITS-1:0] old,
                                                    input logic [WORD_BITS-1:0] data,
                                                    input logic [BYTEEN_BITS-1:0] byteen);
    logic [WORD_BITS-1:0] result;
    result = old;
    for (int b = 0; b < BYTEEN_BITS; b++) begin
        if (byteen[b]) begin
            result[b*8 +: 8] = data[b*8 +: 8];
        end
    end
    return result;
endfunction

function automatic logic [WORD_BITS-1:0] shadow_read(input int key);
    if (shadow_mem.exists(key)) begin
        return shadow_mem[key];
    end
    return fill_pattern(key);
endfunction

function automatic void shadow_write(input int key, input logic [WORD_BITS-1:0] data,
                                     input logic [BYTEEN_BITS-1:0] byteen);
    shadow_mem[key] = merge_word(shadow_read(key), data, byteen);
endfunction

function automatic logic [WORD_BITS-1:0] backing_read(input int key);
    if (backing_mem.exists(key)) begin
        return backing_mem[key];
    end
    return fill_pattern(key);
endfunction

function automatic void backing_write(input int key, input logic [WORD_BITS-1:0] data,
                                      input logic [BYTEEN_BITS-1:0] byteen);
    backing_mem[key] = merge_word(backing_read(key), data, byteen);
endfunction

// true on a read miss; the fill that follows installs the tag
function automatic logic model_read_misses(input logic [LINE_ADDR_BITS-1:0] addr);
    line_addr_t a;
    a.raw = addr;
    if (model_valid[a.split.set] && model_tag[a.split.set] == a.split.tag) begin
        return 1'b0;
    end
    model_valid[a.split.set] = 1'b1;
    model_tag[a.split.set]   = a.split.tag;
    return 1'b1;
endfunction

`endif

// ==== tests/cache_bank_tb.sv ====
/*
 * Cache bank testbench
 * Random reads and writes over a few conflicting lines, random
 * back-pressure and a delayed memory responder, all checked against
 * the reference model of memory and tags.
 */
`timescale 1ns/10ps

module cache_bank_tb
    import cache_pkg::*;
();

    localparam int SEED       = 80;
    localparam int NUM_OPS    = 400;
    localparam int INIT_OP    = 200;
    localparam int WAIT_LIMIT = 2000;

    logic                      clk;
    logic                      reset;
    logic                      core_req_valid;
    logic [LINE_ADDR_BITS-1:0] core_req_addr;
    logic                      core_req_rw;
    logic [WSEL_BITS-1:0]      core_req_wsel;
    logic [BYTEEN_BITS-1:0]    core_req_byteen;
    logic [WORD_BITS-1:0]      core_req_data;
    logic [REQ_TAG_BITS-1:0]   core_req_tag;
    logic                      core_req_ready;
    logic                      core_rsp_valid;
    logic [WORD_BITS-1:0]      core_rsp_data;
    logic [REQ_TAG_BITS-1:0]   core_rsp_tag;
    logic                      core_rsp_ready;
    logic                      mem_req_valid;
    logic [LINE_ADDR_BITS-1:0] mem_req_addr;
    logic                      mem_req_rw;
    logic [WSEL_BITS-1:0]      mem_req_wsel;
    logic [BYTEEN_BITS-1:0]    mem_req_byteen;
    logic [WORD_BITS-1:0]      mem_req_data;
    logic                      mem_req_ready;
    logic                      mem_rsp_valid;
    logic [LINE_BITS-1:0]      mem_rsp_data;
    logic                      mem_rsp_ready;
    logic                      init_enable;
    logic [SET_BITS-1:0]       init_line_sel;

    `include "cache_model.svh"

    // expected responses {tag, data} and memory requests {rw, addr, wsel, byteen, data}
    logic [REQ_TAG_BITS+WORD_BITS-1:0] exp_rsp [$];
    logic [50:0]                       exp_mreq [$];

    logic [31:0]          stim_state;
    logic [31:0]          resp_state;
    logic [31:0]          delay_state;
    logic                 fill_pending;
    logic                 fill_taken;
    int                   fill_delay;
    logic [LINE_BITS-1:0] fill_line;
    int                   reads_issued;
    int                   rsp_count;
    int                   mreq_expected;
    int                   mreq_count;

    cache_bank cache_bank_inst (.*);

    always #4 clk = ~clk;

    function automatic logic [31:0] lcg_step(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // eight lines on four sets
    function automatic logic [LINE_ADDR_BITS-1:0] pool_line(input logic [2:0] idx);
        case (idx)
            3'd0:    return {6'd1, 6'd3};
            3'd1:    return {6'd2, 6'd3};
            3'd2:    return {6'd5, 6'd3};
            3'd3:    return {6'd1, 6'd17};
            3'd4:    return {6'd7, 6'd17};
            3'd5:    return {6'd2, 6'd40};
            3'd6:    return {6'd3, 6'd40};
            default: return {6'd4, 6'd9};
        endcase
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Checks failed");
        $fatal(1, "stopping after a failure");
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("FAILED %s expected %h actual %h", name, expected, actual);
            $display("Checks failed");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    task automatic issue(input logic rw, input logic [LINE_ADDR_BITS-1:0] addr,
                         input logic [WSEL_BITS-1:0] wsel,
                         input logic [BYTEEN_BITS-1:0] byteen,
                         input logic [WORD_BITS-1:0] data,
                         input logic [REQ_TAG_BITS-1:0] tag);
        int   waited;
        logic accepted;
        waited   = 0;
        accepted = 1'b0;
        // model update in acceptance order
        if (rw) begin
            shadow_write(word_key(addr, wsel), data, byteen);
            exp_mreq.push_back({1'b1, addr, wsel, byteen, data});
            mreq_expected++;
        end else begin
            exp_rsp.push_back({tag, shadow_read(word_key(addr, wsel))});
            reads_issued++;
            if (model_read_misses(addr)) begin
                exp_mreq.push_back({1'b0, addr, 38'h0});
                mreq_expected++;
            end
        end
        core_req_valid  = 1'b1;
        core_req_rw     = rw;
        core_req_addr   = addr;
        core_req_wsel   = wsel;
        core_req_byteen = byteen;
        core_req_data   = data;
        core_req_tag    = tag;
        while (!accepted) begin
            @(negedge clk);
            if (core_req_ready) begin
                accepted = 1'b1;
            end else begin
                waited++;
                if (waited > WAIT_LIMIT) begin
                    report_failure("timeout: core request never accepted");
                end
            end
            @(posedge clk);
            #1;
        end
        core_req_valid = 1'b0;
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while (exp_rsp.size() != 0 || exp_mreq.size() != 0) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > WAIT_LIMIT) begin
                report_failure("timeout: outstanding responses or memory requests");
            end
        end
        repeat (3) @(posedge clk);
        #1;
    endtask

    task automatic invalidate_set(input logic [SET_BITS-1:0] set);
        init_enable   = 1'b1;
        init_line_sel = set;
        @(posedge clk);
        #1;
        init_enable       = 1'b0;
        model_valid[set]  = 1'b0;
    endtask

    // output monitors sample at the falling edge where all is stable
    always @(negedge clk) begin : rsp_monitor
        if (!reset && core_rsp_valid && core_rsp_ready) begin
            if (exp_rsp.size() == 0) begin
                report_failure("core response with no read outstanding");
            end else begin
                check_value("core response", 64'(exp_rsp.pop_front()),
                            64'({core_rsp_tag, core_rsp_data}));
                rsp_count++;
            end
        end
        if (!reset && mem_rsp_valid && mem_rsp_ready) begin
            fill_taken = 1'b1;
        end
    end

    always @(negedge clk) begin : mreq_monitor
        logic [50:0] exp_req;
        if (!reset && mem_req_valid && mem_req_ready) begin
            if (exp_mreq.size() == 0) begin
                report_failure("memory request with none expected");
            end else begin
                exp_req = exp_mreq.pop_front();
                mreq_count++;
                if (exp_req[50]) begin
                    check_value("memory write request", 64'(exp_req),
                                64'({mem_req_rw, mem_req_addr, mem_req_wsel,
                                     mem_req_byteen, mem_req_data}));
                    backing_write(word_key(mem_req_addr, mem_req_wsel), mem_req_data,
                                  mem_req_byteen);
                end else begin
                    check_value("memory read request", 64'(exp_req[50:38]),
                                64'({mem_req_rw, mem_req_addr}));
                    if (fill_pending) begin
                        report_failure("second memory read while a fill is pending");
                    end
                    // earlier writes are already in memory when the line is read
                    for (int w = 0; w < WORDS_PER_LINE; w++) begin
                        fill_line[w*WORD_BITS +: WORD_BITS] =
                            backing_read(word_key(mem_req_addr, WSEL_BITS'(w)));
                    end
                    delay_state  = lcg_step(delay_state);
                    fill_delay   = int'(delay_state[20:16]);
                    fill_pending = 1'b1;
                end
            end
        end
    end

    // back-pressure and the memory responder
    always @(posedge clk) begin
        #1;
        if (!reset) begin
            resp_state     = lcg_step(resp_state);
            core_rsp_ready = (resp_state[17:16] != 2'd0);
            mem_req_ready  = (resp_state[19:18] != 2'd0);
            if (fill_taken) begin
                mem_rsp_valid = 1'b0;
                fill_taken    = 1'b0;
                fill_pending  = 1'b0;
            end else if (fill_pending && !mem_rsp_valid) begin
                if (fill_delay == 0) begin
                    mem_rsp_valid = 1'b1;
                    mem_rsp_data  = fill_line;
                end else begin
                    fill_delay--;
                end
            end
        end
    end

    initial begin
        logic [31:0] r;
        logic [31:0] data;
        clk             = 1'b0;
        reset           = 1'b1;
        core_req_valid  = 1'b0;
        core_req_addr   = '0;
        core_req_rw     = 1'b0;
        core_req_wsel   = '0;
        core_req_byteen = '0;
        core_req_data   = '0;
        core_req_tag    = '0;
        core_rsp_ready  = 1'b1;
        mem_req_ready   = 1'b1;
        mem_rsp_valid   = 1'b0;
        mem_rsp_data    = '0;
        init_enable     = 1'b0;
        init_line_sel   = '0;
        stim_state      = SEED;
        resp_state      = SEED + 1;
        delay_state     = SEED + 2;
        fill_pending    = 1'b0;
        fill_taken      = 1'b0;
        fill_delay      = 0;
        fill_line       = '0;
        reads_issued    = 0;
        rsp_count       = 0;
        mreq_expected   = 0;
        mreq_count      = 0;
        for (int s = 0; s < NUM_SETS; s++) begin
            model_valid[s] = 1'b0;
            model_tag[s]   = '0;
        end
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;

        for (int s = 0; s < NUM_SETS; s++) begin
            invalidate_set(SET_BITS'(s));
        end

        for (int op = 0; op < NUM_OPS; op++) begin
            if (op == INIT_OP) begin
                // make the line resident, drop its set and read it back from memory
                wait_drained();
                issue(1'b0, pool_line(3'd0), 2'd1, 4'h0, 32'h0, 4'he);
                wait_drained();
                invalidate_set(SET_BITS'(pool_line(3'd0)));
                issue(1'b0, pool_line(3'd0), 2'd1, 4'h0, 32'h0, 4'hf);
            end
            stim_state = lcg_step(stim_state);
            r          = stim_state;
            stim_state = lcg_step(stim_state);
            data       = {stim_state[31:16], 16'h0};
            stim_state = lcg_step(stim_state);
            data       = data | {16'h0, stim_state[31:16]};
            issue(r[16] & r[17], pool_line(r[20:18]), r[22:21], r[26:23], data,
                  REQ_TAG_BITS'(op));
            if (r[28:27] == 2'd0) begin
                @(posedge clk);
                #1;
            end
        end

        wait_drained();
        // an item still offered after the drain counts as an extra one
        check_value("core response count", 64'(reads_issued),
                    64'(rsp_count + int'(core_rsp_valid)));
        check_value("memory request count", 64'(mreq_expected),
                    64'(mreq_count + int'(mem_req_valid)));
        $display("All checks passed");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+tests
hw/cache_pkg.sv
hw/sync_fifo.sv
hw/tag_store.sv
hw/data_store.sv
hw/miss_slot.sv
hw/cache_bank.sv
tests/cache_bank_tb.sv
